// File: common/vga_pkg.sv
package vga_pkg;

    // horizontal timing, 640x480 at 60 hz
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 800 clocks per line

    localparam int h_sync_start = h_active + h_front;  // first sync-low pixel
    localparam int h_sync_end   = h_sync_start + h_sync;  // first pixel of back porch

    // vertical timing, in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 525 lines per frame

    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    // tile grid and palette
    localparam int tile_px     = 16;  // tile edge in pixels
    localparam int tile_shift  = $clog2(tile_px);  // pixel to tile coordinate
    localparam int tiles_x     = 40;
    localparam int tiles_y     = 30;
    localparam int tile_count  = tiles_x * tiles_y;  // 1200 entries
    localparam int pal_entries = 16;

    // host controller states
    localparam logic [1:0] ctrl_idle  = 2'd0;
    localparam logic [1:0] ctrl_write = 2'd1;  // strobe cycle
    localparam logic [1:0] ctrl_ack   = 2'd2;  // ack held until req drops

    // one pixel clock of the raster
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;
        logic       hsync_n;  // active low
        logic       vsync_n;  // active low
    } beam_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // payload when the command writes a tile
    typedef struct packed {
        logic [1:0] unused;
        logic [4:0] tile_y;
        logic [5:0] tile_x;
        logic [3:0] color_idx;
    } tile_cmd_t;

    // payload when the command writes a palette entry
    typedef struct packed {
        logic [3:0] pal_idx;
        rgb_t       color;
        logic       unused;
    } pal_cmd_t;

    // same 17 bits, two decodings picked by is_palette
    typedef union packed {
        tile_cmd_t tile;
        pal_cmd_t  pal;
    } cmd_payload_u;

    typedef struct packed {
        logic         is_palette;
        cmd_payload_u payload;
    } host_cmd_t;

    typedef struct packed {
        logic        en;    // single-cycle strobe
        logic [10:0] addr;  // tile_y * 40 + tile_x
        logic [3:0]  idx;
    } tile_wr_t;

    typedef struct packed {
        logic       en;
        logic [3:0] idx;
        rgb_t       color;
    } pal_wr_t;

    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        rgb_t rgb;
    } vga_out_t;

endpackage

// File: design/palette_lut.sv
`timescale 1ns/1ps

// 16 entry colour lookup, index to 12 bit rgb
module palette_lut import vga_pkg::*; (
    input  logic       clk_25mhz,
    input  logic       rst,
    input  pal_wr_t    pal_wr,
    input  logic [3:0] rd_idx,
    output rgb_t       rd_color
);

    rgb_t pal [pal_entries];  // colour registers

    // entries start black after reset
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            for (int i = 0; i < pal_entries; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_wr.en) begin
            pal[pal_wr.idx] <= pal_wr.color;  // host update
        end
    end

    // registered read, feeds the output stage of the pixel pipe
    always_ff @(posedge clk_25mhz) begin
        rd_color <= pal[rd_idx];
    end

endmodule

// File: design/pixel_pipe.sv
`timescale 1ns/1ps

// beam to pixel: tile read, palette read, output register
module pixel_pipe import vga_pkg::*; (
    input  logic        clk_25mhz,
    input  logic        rst,
    input  beam_t       beam,
    output logic [10:0] rd_addr,   // to tile_ram
    input  logic [3:0]  rd_idx,    // from tile_ram
    output logic [3:0]  pal_idx,   // to palette_lut
    input  rgb_t        rd_color,  // from palette_lut
    output vga_out_t    vga
);

    logic [5:0]  tile_col;  // x / 16, up to 49 in blanking
    logic [5:0]  tile_row;  // y / 16, up to 32 in blanking
    logic [10:0] lin_addr;
    logic [1:0]  hs_d;      // sync and active follow the two memory reads
    logic [1:0]  vs_d;
    logic [1:0]  act_d;

    assign tile_col = 6'(beam.x >> tile_shift);
    assign tile_row = 6'(beam.y >> tile_shift);
    assign lin_addr = 11'(tile_row) * 11'(tiles_x) + 11'(tile_col);

    // park the read on entry 0 in blanking so it never leaves the array
    assign rd_addr = beam.active ? lin_addr : '0;

    // tile index goes straight into the palette read
    assign pal_idx = rd_idx;

    // stages 1 and 2, matching the tile and palette read latency
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            hs_d  <= 2'b11;
            vs_d  <= 2'b11;
            act_d <= 2'b00;
        end else begin
            hs_d  <= {hs_d[0], beam.hsync_n};
            vs_d  <= {vs_d[0], beam.vsync_n};
            act_d <= {act_d[0], beam.active};
        end
    end

    // stage 3, output register with blanking
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            vga.hsync_n <= 1'b1;
            vga.vsync_n <= 1'b1;
            vga.rgb     <= '0;
        end else begin
            vga.hsync_n <= hs_d[1];
            vga.vsync_n <= vs_d[1];
            if (act_d[1]) begin
                vga.rgb <= rd_color;
            end else begin
                vga.rgb <= '0;  // rgb must be black in porches and sync
            end
        end
    end

endmodule

// File: design/tile_ram.sv
`timescale 1ns/1ps

// colour index per tile, one write port and one registered read port
module tile_ram import vga_pkg::*; (
    input  logic        clk_25mhz,
    input  tile_wr_t    tile_wr,
    input  logic [10:0] rd_addr,  // row * 40 + column
    output logic [3:0]  rd_idx
);

    logic [3:0] mem [tile_count];  // 1200 x 4, contents undefined after power up

    // write port, one strobe per host command
    always_ff @(posedge clk_25mhz) begin
        if (tile_wr.en) begin
            mem[tile_wr.addr] <= tile_wr.idx;
        end
    end

    // read port, one clock latency
    // a write and read to the same entry in one clock returns the old index
    always_ff @(posedge clk_25mhz) begin
        rd_idx <= mem[rd_addr];
    end

endmodule

// File: design/vga_display_top.sv
`timescale 1ns/1ps

// tile based 640x480 display: timing, host port, tile and palette memories
module vga_display_top import vga_pkg::*; (
    input  logic      clk_25mhz,
    input  logic      rst,
    input  logic      req,
    input  host_cmd_t cmd,
    output logic      ack,
    output vga_out_t  vga
);

    beam_t       beam;      // raster position, one clock behind the counters
    tile_wr_t    tile_wr;
    pal_wr_t     pal_wr;
    logic [10:0] tile_addr;
    logic [3:0]  tile_idx;  // tile_ram -> pixel_pipe
    logic [3:0]  pal_idx;   // pixel_pipe -> palette_lut
    rgb_t        pal_color;

    vga_timing timing0 (
        .clk_25mhz (clk_25mhz),
        .rst       (rst),
        .beam      (beam)
    );

    vga_host_ctrl ctrl0 (
        .clk_25mhz (clk_25mhz),
        .rst       (rst),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .tile_wr   (tile_wr),
        .pal_wr    (pal_wr)
    );

    tile_ram tiles0 (
        .clk_25mhz (clk_25mhz),
        .tile_wr   (tile_wr),
        .rd_addr   (tile_addr),
        .rd_idx    (tile_idx)
    );

    palette_lut pal0 (
        .clk_25mhz (clk_25mhz),
        .rst       (rst),
        .pal_wr    (pal_wr),
        .rd_idx    (pal_idx),
        .rd_color  (pal_color)
    );

    // output lands 3 clocks after beam, 4 after the counters
    pixel_pipe pipe0 (
        .clk_25mhz (clk_25mhz),
        .rst       (rst),
        .beam      (beam),
        .rd_addr   (tile_addr),
        .rd_idx    (tile_idx),
        .pal_idx   (pal_idx),
        .rd_color  (pal_color),
        .vga       (vga)
    );

endmodule

// File: design/vga_host_ctrl.sv
`timescale 1ns/1ps

// four-phase req/ack slave that turns host commands into memory write strobes
module vga_host_ctrl import vga_pkg::*; (
    input  logic      clk_25mhz,
    input  logic      rst,
    input  logic      req,
    input  host_cmd_t cmd,
    output logic      ack,
    output tile_wr_t  tile_wr,
    output pal_wr_t   pal_wr
);

    logic [1:0] state;
    host_cmd_t  cmd_q;     // command captured at accept
    tile_cmd_t  tile_view;
    pal_cmd_t   pal_view;
    logic       in_range;  // tile coordinates inside the 40x30 grid
    logic       wr_cycle;

    // handshake FSM
    // idle -> write on the first req high, write -> ack always,
    // ack -> idle once req is seen low
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            state <= ctrl_idle;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (req) begin
                        state <= ctrl_write;  // accept cycle
                    end
                end
                ctrl_write: begin
                    state <= ctrl_ack;  // strobe lasts one clock
                end
                ctrl_ack: begin
                    if (!req) begin
                        state <= ctrl_idle;
                    end
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // command register, loaded only on accept
    always_ff @(posedge clk_25mhz) begin
        if ((state == ctrl_idle) && req) begin
            cmd_q <= cmd;
        end
    end

    assign ack      = (state == ctrl_ack);  // rises the cycle after the strobe
    assign wr_cycle = (state == ctrl_write);

    // both views of the same payload bits
    assign tile_view = cmd_q.payload.tile;
    assign pal_view  = cmd_q.payload.pal;

    // out of range tiles still get acked, they just write nothing
    assign in_range = (tile_view.tile_x < 6'(tiles_x)) && (tile_view.tile_y < 5'(tiles_y));

    // tile write, linear address y*40 + x
    assign tile_wr.en   = wr_cycle && !cmd_q.is_palette && in_range;
    assign tile_wr.addr = 11'(tile_view.tile_y) * 11'(tiles_x) + 11'(tile_view.tile_x);
    assign tile_wr.idx  = tile_view.color_idx;

    // palette write
    assign pal_wr.en    = wr_cycle && cmd_q.is_palette;
    assign pal_wr.idx   = pal_view.pal_idx;
    assign pal_wr.color = pal_view.color;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the vga display testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module vga_tb -f vga_display.f -o vga_sim

out=$(./obj_dir/vga_sim)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: timing/vga_timing.sv
`timescale 1ns/1ps

// raster generator for the fixed 640x480 mode
module vga_timing import vga_pkg::*; (
    input  logic  clk_25mhz,
    input  logic  rst,
    output beam_t beam
);

    logic [9:0] x_cnt;  // pixel within line
    logic [9:0] y_cnt;  // line within frame
    logic       x_last;

    assign x_last = (x_cnt == 10'(h_total - 1));  // last clock of the line

    // horizontal counter, wraps at 799
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            x_cnt <= '0;
        end else if (x_last) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + 10'd1;
        end
    end

    // vertical counter steps once per line
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            y_cnt <= '0;
        end else if (x_last) begin
            if (y_cnt == 10'(v_total - 1)) begin
                y_cnt <= '0;  // new frame
            end else begin
                y_cnt <= y_cnt + 10'd1;
            end
        end
    end

    // beam lags the counters by one clock
    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            beam.x       <= '0;
            beam.y       <= '0;
            beam.active  <= 1'b0;
            beam.hsync_n <= 1'b1;  // idle high
            beam.vsync_n <= 1'b1;
        end else begin
            beam.x <= x_cnt;
            beam.y <= y_cnt;
            // visible region is the top left 640x480
            beam.active <= (x_cnt < 10'(h_active)) && (y_cnt < 10'(v_active));
            // sync low between front and back porch
            beam.hsync_n <= !((x_cnt >= 10'(h_sync_start)) && (x_cnt < 10'(h_sync_end)));
            beam.vsync_n <= !((y_cnt >= 10'(v_sync_start)) && (y_cnt < 10'(v_sync_end)));
        end
    end

endmodule

// File: verification/vga_tb.sv
`timescale 1ns/1ps

// testbench for the tile display with host writes checked against a pixel model
module vga_tb import vga_pkg::*; ();

    localparam longint frame_ns   = longint'(h_total) * longint'(v_total) * 40;
    localparam longint timeout_ns = 5 * frame_ns + 4_000_000;  // five frames plus handshakes

    logic      clk_25mhz;
    logic      rst;
    logic      req;
    host_cmd_t cmd;
    logic      ack;
    vga_out_t  vga;

    integer     seed = 32'h8e4d;
    int         mismatch_errs = 0;
    int         hs_errs = 0;       // handshake protocol
    int         other_errs = 0;
    int         checked_px = 0;
    int         post_rst = 0;      // negedges since reset release
    int         mx = 0;            // raster position of the pixel on the output
    int         my = 0;
    logic       synced = 1'b0;
    logic       prev_vs = 1'b1;
    logic       check_px = 1'b0;   // active pixels compared only after the fill
    logic [3:0] mtile [tile_count];
    rgb_t       mpal [pal_entries];
    event       vs_fall;

    vga_display_top dut0 (
        .clk_25mhz (clk_25mhz),
        .rst       (rst),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .vga       (vga)
    );

    initial clk_25mhz = 1'b0;
    always #20 clk_25mhz = ~clk_25mhz;  // 25 mhz

    // model update when the handshake completes
    task automatic update_model(input host_cmd_t c);
        if (c.is_palette) begin
            mpal[c.payload.pal.pal_idx] = c.payload.pal.color;
        end else if (c.payload.tile.tile_x < 40 && c.payload.tile.tile_y < 30) begin
            mtile[c.payload.tile.tile_y * 40 + c.payload.tile.tile_x] = c.payload.tile.color_idx;
        end  // out of range leaves the model alone
    endtask

    // four-phase handshake with timing checks
    task automatic send_cmd(input host_cmd_t c);
        int wait_n;
        int hold_n;
        @(posedge clk_25mhz);
        #2;
        cmd = c;  // cmd settles a clock before req
        @(posedge clk_25mhz);
        #2;
        req = 1'b1;
        wait_n = 0;
        while (!ack && wait_n < 8) begin
            @(posedge clk_25mhz);
            #2;
            wait_n++;
        end
        if (!ack) begin
            $display("ERROR at %0t: ack did not rise within 8 cycles of req", $time);
            hs_errs++;
        end else begin
            update_model(c);
        end
        hold_n = $random(seed) & 3;  // host lingers a little
        repeat (hold_n) begin
            @(posedge clk_25mhz);
            #2;
            if (!ack) begin
                $display("ERROR at %0t: ack dropped while req was still high", $time);
                hs_errs++;
            end
        end
        req = 1'b0;
        wait_n = 0;
        while (ack && wait_n < 3) begin
            @(posedge clk_25mhz);
            #2;
            wait_n++;
        end
        if (ack) begin
            $display("ERROR at %0t: ack still high 3 cycles after req fell", $time);
            hs_errs++;
        end
    endtask

    task automatic make_tile_cmd(output host_cmd_t c, input int tx, input int ty);
        c = '0;
        c.payload.tile.tile_x    = 6'(tx);
        c.payload.tile.tile_y    = 5'(ty);
        c.payload.tile.color_idx = 4'($random(seed));
    endtask

    task automatic make_pal_cmd(output host_cmd_t c, input int idx);
        c = '0;
        c.is_palette          = 1'b1;
        c.payload.pal.pal_idx = 4'(idx);
        c.payload.pal.color   = 12'($random(seed));
    endtask

    // expected pixel is the palette colour of the tile under the beam and black in blanking
    function automatic rgb_t expected_rgb(input int px, input int py);
        if (px < h_active && py < v_active) begin
            return mpal[mtile[(py / tile_px) * tiles_x + px / tile_px]];
        end
        return '0;
    endfunction

    // output monitor samples on the falling edge
    always @(negedge clk_25mhz) begin
        if (rst) begin
            if (ack !== 1'b0 || vga.hsync_n !== 1'b1 || vga.vsync_n !== 1'b1 ||
                vga.rgb !== '0) begin
                $display("MISMATCH at %0t: reset state ack=%b hs=%b vs=%b rgb=%h", $time,
                         ack, vga.hsync_n, vga.vsync_n, vga.rgb);
                mismatch_errs++;
            end
        end else begin
            if (post_rst < 3 && vga.rgb !== '0) begin  // pipe still flushing
                $display("MISMATCH at %0t: rgb=%h right after reset", $time, vga.rgb);
                mismatch_errs++;
            end
            post_rst++;
            if (synced) begin
                mx++;
                if (mx == h_total) begin
                    mx = 0;
                    my = (my == v_total - 1) ? 0 : my + 1;
                end
            end else if (prev_vs && !vga.vsync_n) begin
                mx = 0;                  // first vsync-low pixel
                my = v_active + v_front;
                synced = 1'b1;
            end
            if (synced) begin
                if (vga.hsync_n !== !(mx >= 656 && mx < 752)) begin
                    $display("MISMATCH at %0t: hsync_n=%b at x=%0d y=%0d", $time,
                             vga.hsync_n, mx, my);
                    mismatch_errs++;
                end
                if (vga.vsync_n !== !(my >= 490 && my < 492)) begin
                    $display("MISMATCH at %0t: vsync_n=%b at x=%0d y=%0d", $time,
                             vga.vsync_n, mx, my);
                    mismatch_errs++;
                end
                if (mx < h_active && my < v_active) begin
                    if (check_px) begin
                        checked_px++;
                        if (vga.rgb !== expected_rgb(mx, my)) begin
                            $display("MISMATCH at %0t: rgb=%h expected %h at x=%0d y=%0d",
                                     $time, vga.rgb, expected_rgb(mx, my), mx, my);
                            mismatch_errs++;
                        end
                    end
                end else if (vga.rgb !== '0) begin
                    $display("MISMATCH at %0t: rgb=%h in blanking at x=%0d y=%0d", $time,
                             vga.rgb, mx, my);
                    mismatch_errs++;
                end
            end
            if (prev_vs && !vga.vsync_n) begin
                -> vs_fall;
            end
            prev_vs = vga.vsync_n;
        end
    end

    // stimulus
    initial begin
        host_cmd_t c;
        int        n;
        rst = 1'b1;
        req = 1'b0;
        cmd = '0;
        for (int i = 0; i < pal_entries; i++) begin
            mpal[i] = '0;  // palette comes out of reset black
        end
        repeat (10) @(posedge clk_25mhz);
        #2;
        rst = 1'b0;
        // fill every tile and then write a few off the grid
        for (int ty = 0; ty < tiles_y; ty++) begin
            for (int tx = 0; tx < tiles_x; tx++) begin
                make_tile_cmd(c, tx, ty);
                send_cmd(c);
            end
        end
        for (int i = 0; i < 6; i++) begin
            make_tile_cmd(c, 40 + i * 4, i * 6);
            send_cmd(c);
            make_tile_cmd(c, i, 30 + (i & 1));
            send_cmd(c);
        end
        for (int p = 0; p < pal_entries; p++) begin
            make_pal_cmd(c, p);
            send_cmd(c);
        end
        @(vs_fall);
        check_px = 1'b1;  // next frame is fully compared
        // random mixed updates only inside the vsync pulse
        repeat (2) begin
            @(vs_fall);
            n = 0;
            while (!vga.vsync_n && n < 24) begin
                if (($random(seed) & 3) == 0) begin
                    make_pal_cmd(c, $random(seed) & 15);
                end else begin
                    make_tile_cmd(c, $random(seed) & 63, $random(seed) & 31);
                end
                send_cmd(c);
                n++;
            end
        end
        @(vs_fall);
        if (checked_px < 3 * h_active * v_active) begin
            $display("ERROR: only %0d active pixels were compared", checked_px);
            other_errs++;
        end
        $display("errors: %0d mismatches, %0d handshake, %0d other, %0d pixels checked",
                 mismatch_errs, hs_errs, other_errs, checked_px);
        if (mismatch_errs + hs_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("ERROR: simulation timed out before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: vga_display.f
common/vga_pkg.sv
timing/vga_timing.sv
design/vga_host_ctrl.sv
design/tile_ram.sv
design/palette_lut.sv
design/pixel_pipe.sv
design/vga_display_top.sv
verification/vga_tb.sv
